// File: Bender.yml
package:
  name: scsi_dma

sources:
  - verilog/scsiDmaPkg.sv
  - verilog/scsiSeqCtrl.sv
  - verilog/longFifo.sv
  - verilog/laneAssembler.sv
  - verilog/chipBusPort.sv
  - verilog/scsiDmaTop.sv
  - target: test
    files:
      - tests/scsiDmaTb.sv

// File: files.f
verilog/scsiDmaPkg.sv
verilog/scsiSeqCtrl.sv
verilog/longFifo.sv
verilog/laneAssembler.sv
verilog/chipBusPort.sv
verilog/scsiDmaTop.sv
tests/scsiDmaTb.sv

// File: tests/scsiDmaTb.sv
`default_nettype none

module scsiDmaTb
    import scsiDmaPkg::*;
();

    localparam int Limit     = 2000;          // Cycles allowed per wait loop
    localparam int FifoLongs = 8;             // Default DUT depth
    localparam int NumRows   = 7;

    typedef enum logic [1:0] {CpuRead, CpuWrite, DmaMove} kindT;

    typedef struct packed {
        kindT       kind;
        logic       dir;                      // 0 = SCSI to FIFO
        logic [7:0] count;                    // DMA bytes, multiple of 4
        byteT       regVal;                   // Register value for CPU rows
        logic       memOn;                    // Memory pops from the start
    } rowT;

    rowT stimTable [NumRows] = '{
        '{CpuRead,  1'b0, 8'd0,  8'hA5, 1'b1},
        '{CpuWrite, 1'b0, 8'd0,  8'h3C, 1'b1},
        '{DmaMove,  1'b0, 8'd16, 8'h00, 1'b1},
        '{DmaMove,  1'b1, 8'd20, 8'h00, 1'b1},
        '{DmaMove,  1'b0, 8'd40, 8'h00, 1'b0},   // Back-pressure row
        '{CpuRead,  1'b0, 8'd0,  8'h5A, 1'b1},
        '{DmaMove,  1'b1, 8'd40, 8'h00, 1'b1}    // More longs than the FIFO holds
    };

    logic       CLK135;
    logic       AS_          = 1'b1;
    logic       dreqN_i;
    byteT       scsiRdData_i = '0;
    chipStrobeT chip_o;
    byteT       scsiWrData_o;
    logic       cpuReq_i     = 1'b0;
    logic       cpuRw_i      = 1'b0;
    byteT       cpuWrData_i  = '0;
    logic       cpuAck_o;
    byteT       cpuRdData_o;
    logic       memPush_i    = 1'b0;
    longT       memWrData_i  = '0;
    logic       memPop_i     = 1'b0;
    longT       memRdData_o;
    logic       fifoFull_o;
    logic       fifoEmpty_o;
    logic       dmaDir_i     = 1'b0;

    byteT        chipRegs [4];                // Chip register file
    int          regSel    = 0;
    byteT        srcBytes [64];               // Bytes the chip sends
    byteT        rxBytes [64];                // Bytes the chip received
    longT        pushLongs [16];
    longT        popLongs [16];
    int          remain    = 0;               // Chip bytes still requested
    int          srcIdx    = 0;
    int          rxIdx     = 0;
    int          dackCount = 0;
    int          popIdx    = 0;
    int          pushIdx   = 0;
    int          pushTotal = 0;
    logic        popEn     = 1'b0;
    logic [31:0] seed;
    int          testErrs  = 0;
    int          errCount  = 0;
    int          testsRun  = 0;
    int          cleanRuns = 0;

    scsiDmaTop i_dut (
        .CLK135, .AS_, .dreqN_i, .scsiRdData_i, .chip_o, .scsiWrData_o,
        .cpuReq_i, .cpuRw_i, .cpuWrData_i, .cpuAck_o, .cpuRdData_o,
        .memPush_i, .memWrData_i, .memPop_i, .memRdData_o,
        .fifoFull_o, .fifoEmpty_o, .dmaDir_i
    );

    initial begin
        CLK135 = 1'b0;
        forever #10 CLK135 = ~CLK135;
    end

    assign dreqN_i = (remain == 0);           // Request held low while bytes remain

    // Chip model, reacts inside each strobe cycle
    always @(negedge CLK135) begin
        if (chip_o.cs && chip_o.re)
            scsiRdData_i <= chipRegs[regSel];
        if (chip_o.cs && chip_o.we)
            chipRegs[regSel] <= scsiWrData_o;
        if (chip_o.dack) begin
            dackCount <= dackCount + 1;
            remain    <= remain - 1;          // Last byte raises the request
            if (chip_o.re) begin
                scsiRdData_i <= srcBytes[srcIdx];
                srcIdx       <= srcIdx + 1;
            end
            if (chip_o.we) begin
                rxBytes[rxIdx] <= scsiWrData_o;
                rxIdx          <= rxIdx + 1;
            end
        end
    end

    // Memory model, pops or fills from the flags of the previous edge
    always @(negedge CLK135) begin
        memPop_i  <= 1'b0;
        memPush_i <= 1'b0;
        if (popEn && !fifoEmpty_o) begin
            popLongs[popIdx] <= memRdData_o;   // Show-ahead head
            popIdx           <= popIdx + 1;
            memPop_i         <= 1'b1;
        end
        if (pushIdx < pushTotal && !fifoFull_o) begin
            memWrData_i <= pushLongs[pushIdx];
            memPush_i   <= 1'b1;
            pushIdx     <= pushIdx + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            testErrs++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR %s", what);
        testErrs++;
    endtask

    task automatic closeTest(input string label);
        $display("%s: %s", label, (testErrs == 0) ? "ok" : "mismatches seen");
        errCount += testErrs;
        cleanRuns += (testErrs == 0);
        testsRun++;
        testErrs = 0;
    endtask

    task automatic checkResetState();
        compareValue("chip_o", chip_o, 4'h0);
        compareValue("cpuAck_o", cpuAck_o, 1'b0);
        compareValue("fifoEmpty_o", fifoEmpty_o, 1'b1);
        compareValue("fifoFull_o", fifoFull_o, 1'b0);
    endtask

    // Holds the request until the acknowledge, then releases it
    task automatic cpuAccess(input logic rw, input byteT wrByte);
        int n;
        cpuRw_i     <= rw;
        cpuWrData_i <= wrByte;
        cpuReq_i    <= 1'b1;
        n = 0;
        while (!cpuAck_o && n < Limit) begin
            @(negedge CLK135);
            n++;
        end
        cpuReq_i <= 1'b0;
        if (!cpuAck_o) begin
            reportProblem("CPU request was never acknowledged");
        end else begin
            @(negedge CLK135);
            compareValue("cpuAck_o", cpuAck_o, 1'b0);  // Pulse is one cycle wide
        end
        repeat (3) @(negedge CLK135);         // Sequencer back to Idle
    endtask

    task automatic runCpuRead(input rowT row, input int sel);
        chipRegs[sel] <= row.regVal;
        regSel        <= sel;
        cpuAccess(1'b1, 8'h00);
        compareValue("cpuRdData_o", cpuRdData_o, row.regVal);
    endtask

    task automatic runCpuWrite(input rowT row, input int sel);
        chipRegs[sel] <= ~row.regVal;         // Stale value must be overwritten
        regSel        <= sel;
        dackCount     <= 0;
        cpuAccess(1'b0, row.regVal);
        compareValue("scsiWrData_o", chipRegs[sel], row.regVal);
        compareValue("dack count", dackCount, 0);
    endtask

    task automatic runDma(input rowT row);
        int   n;
        int   k;
        int   last;
        int   settle;
        longT expLong;
        byteT expByte;
        for (k = 0; k < row.count; k++) begin
            seed        = xorshift(seed);
            srcBytes[k] = seed[7:0];
        end
        for (k = 0; k < row.count / 4; k++) begin
            seed         = xorshift(seed);
            pushLongs[k] = seed;
        end
        dmaDir_i  <= row.dir;
        srcIdx    <= 0;
        rxIdx     <= 0;
        popIdx    <= 0;
        pushIdx   <= 0;
        dackCount <= 0;
        popEn     <= !row.dir && row.memOn;
        pushTotal <= row.dir ? row.count / 4 : 0;
        remain    <= row.count;
        if (!row.dir && !row.memOn) begin     // Stall until dack count stops moving
            last   = -1;
            settle = 0;
            n      = 0;
            while (settle < 12 && n < Limit) begin
                @(negedge CLK135);
                n++;
                if (dackCount == last) begin
                    settle++;
                end else begin
                    settle = 0;
                    last   = dackCount;
                end
            end
            if (settle < 12)
                reportProblem("DMA strobes never stopped with a full FIFO");
            compareValue("dack count", dackCount, FifoLongs * 4 + 3);
            compareValue("fifoFull_o", fifoFull_o, 1'b1);
            popEn <= 1'b1;
        end
        n = 0;
        while (!(remain == 0 && chip_o == '0 &&
                 (row.dir ? (rxIdx == row.count)
                          : (popIdx == row.count / 4))) && n < Limit) begin
            @(negedge CLK135);
            n++;
        end
        if (n == Limit)
            reportProblem("DMA transfer did not finish in time");
        if (!row.dir) begin
            for (k = 0; k < row.count / 4; k++) begin
                expLong = {srcBytes[4*k], srcBytes[4*k+1], srcBytes[4*k+2], srcBytes[4*k+3]};
                compareValue($sformatf("memRdData_o[%0d]", k), popLongs[k], expLong);
            end
        end else begin
            for (k = 0; k < row.count; k++) begin
                expByte = byteT'(pushLongs[k / 4] >> (8 * (3 - k % 4)));  // MSB lane first
                compareValue($sformatf("scsiWrData_o[%0d]", k), rxBytes[k], expByte);
            end
            compareValue("fifoEmpty_o", fifoEmpty_o, 1'b1);
        end
        popEn     <= 1'b0;
        pushTotal <= 0;
        pushIdx   <= 0;
        repeat (3) @(negedge CLK135);
        compareValue("dack count", dackCount, row.count);  // No strobe after the last byte
    endtask

    initial begin
        int r;
        seed = 32'd87487;
        for (int k = 0; k < 4; k++)
            chipRegs[k] <= byteT'(8'h07 + k * 8'h11);
        @(negedge CLK135);
        checkResetState();                    // Inside reset
        @(negedge CLK135);
        AS_ <= 1'b0;
        @(negedge CLK135);
        checkResetState();                    // First cycle out of reset
        closeTest("reset");
        for (r = 0; r < NumRows; r++) begin
            case (stimTable[r].kind)
                CpuRead:  runCpuRead(stimTable[r], r % 4);
                CpuWrite: runCpuWrite(stimTable[r], r % 4);
                default:  runDma(stimTable[r]);
            endcase
            closeTest($sformatf("row %0d kind %0d dir %0d count %0d", r,
                                stimTable[r].kind, stimTable[r].dir, stimTable[r].count));
        end
        $display("%0d tests run, %0d clean, %0d errors", testsRun, cleanRuns, errCount);
        if (errCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/chipBusPort.sv
`default_nettype none

module chipBusPort
    import scsiDmaPkg::*;
(
    input  wire    CLK135,
    input  wire    AS_,
    input  dmaCtlT dmaCtl_i,
    input  byteT   cpuWrData_i,
    input  byteT   laneByte_i,      // From the lane selector
    input  byteT   scsiRdData_i,
    output byteT   scsiWrData_o,    // Chip write bus
    output byteT   cpuRdData_o      // Held until next CPU read
);

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_)
            cpuRdData_o <= '0;
        else if (dmaCtl_i.s2cpu)
            cpuRdData_o <= scsiRdData_i;  // End of the CPU read cycle
    end

    // CPU write takes the bus, DMA lane otherwise
    assign scsiWrData_o = dmaCtl_i.cpu2s ? cpuWrData_i : laneByte_i;

endmodule

`default_nettype wire

// File: verilog/laneAssembler.sv
`default_nettype none

module laneAssembler
    import scsiDmaPkg::*;
(
    input  wire    CLK135,
    input  wire    AS_,
    input  dmaCtlT dmaCtl_i,
    input  byteT   scsiRdData_i,     // Valid while re is high
    input  longT   headLong_i,       // FIFO head
    output byteT   laneByte_o,       // Outgoing lane at the pointer
    output logic   boEq3_o,
    output longT   packedLong_o,
    output logic   packPush_o,
    output logic   packPop_o
);

    bytePtrT bytePtr;
    byteT    laneHold [3];           // Lanes 0..2 waiting for lane 3

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_)
            bytePtr <= '0;
        else if (dmaCtl_i.s2f || dmaCtl_i.f2s)
            bytePtr <= bytePtr + 1'b1;  // Wraps after lane 3
    end

    // Lane 3 never lands here, it goes straight into the push word
    always_ff @(posedge CLK135) begin
        if (dmaCtl_i.s2f && !boEq3_o)
            laneHold[bytePtr] <= scsiRdData_i;
    end

    assign boEq3_o      = (bytePtr == 2'd3);
    assign packedLong_o = {laneHold[0], laneHold[1], laneHold[2], scsiRdData_i};  // Big-endian
    assign packPush_o   = dmaCtl_i.s2f && boEq3_o;
    assign packPop_o    = dmaCtl_i.f2s && boEq3_o;   // Head done after its last lane

    always_comb begin
        case (bytePtr)
            2'd0:    laneByte_o = headLong_i[31:24];  // MSB first
            2'd1:    laneByte_o = headLong_i[23:16];
            2'd2:    laneByte_o = headLong_i[15:8];
            default: laneByte_o = headLong_i[7:0];
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/longFifo.sv
`default_nettype none

module longFifo
    import scsiDmaPkg::*;
#(
    parameter int FifoDepthLog2 = 3
) (
    input  wire  CLK135,
    input  wire  AS_,
    input  wire  packPush_i,           // Push from packer
    input  longT packedLong_i,
    input  wire  packPop_i,            // Pop by lane sender
    input  wire  memPush_i,            // Push from memory side
    input  longT memWrData_i,
    input  wire  memPop_i,             // Pop by memory side
    output longT headLong_o,           // Show-ahead head
    output logic full_o,
    output logic empty_o
);

    localparam int Depth = 1 << FifoDepthLog2;

    longT                   fifoMem [Depth];   // Longword storage
    logic [FifoDepthLog2:0] nextIn;            // Extra MSB is the wrap bit
    logic [FifoDepthLog2:0] nextOut;
    logic                   push;
    logic                   pop;
    longT                   wrData;

    assign push   = packPush_i || memPush_i;
    assign pop    = packPop_i || memPop_i;
    assign wrData = packPush_i ? packedLong_i : memWrData_i;  // Follows the pusher

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            nextIn  <= '0;
            nextOut <= '0;
        end else begin
            if (push)
                nextIn <= nextIn + 1'b1;
            if (pop)
                nextOut <= nextOut + 1'b1;
        end
    end

    always_ff @(posedge CLK135) begin
        if (push)
            fifoMem[nextIn[FifoDepthLog2-1:0]] <= wrData;
    end

    assign headLong_o = fifoMem[nextOut[FifoDepthLog2-1:0]];
    assign empty_o    = (nextIn == nextOut);
    assign full_o     = (nextIn[FifoDepthLog2] != nextOut[FifoDepthLog2]) &&
                        (nextIn[FifoDepthLog2-1:0] == nextOut[FifoDepthLog2-1:0]);

    assert property (@(posedge CLK135) disable iff (AS_) !(push && full_o))
        else $error("longFifo: push while full");

    assert property (@(posedge CLK135) disable iff (AS_) !(pop && empty_o))
        else $error("longFifo: pop while empty");

    // Packer and memory own opposite directions
    assert property (@(posedge CLK135) disable iff (AS_) !(packPush_i && memPush_i))
        else $error("longFifo: packer and memory push together");

endmodule

`default_nettype wire

// File: verilog/scsiDmaPkg.sv
`default_nettype none

package scsiDmaPkg;

    typedef logic [7:0]  byteT;     // One chip data byte
    typedef logic [31:0] longT;     // One FIFO longword
    typedef logic [1:0]  bytePtrT;  // Lane index, 0 is bits 31..24

    // Chip pins, all active high here
    typedef struct packed {
        logic cs;                   // Register select for CPU access
        logic re;                   // Read strobe
        logic we;                   // Write strobe
        logic dack;                 // DMA acknowledge
    } chipStrobeT;

    // Sequencer to datapath controls
    typedef struct packed {
        logic s2f;                  // Chip byte into packer
        logic f2s;                  // FIFO lane byte out to chip
        logic cpu2s;                // CPU byte on write bus
        logic s2cpu;                // Latch chip read data for CPU
    } dmaCtlT;

    typedef enum logic [2:0] {
        Idle,
        CpuAccess,
        CpuDone,
        DmaStrobe,
        DmaRecover
    } seqStateT;

endpackage

`default_nettype wire

// File: verilog/scsiDmaTop.sv
`default_nettype none

module scsiDmaTop
    import scsiDmaPkg::*;
#(
    parameter int FifoDepthLog2 = 3     // 8 longwords by default
) (
    input  wire        CLK135,
    input  wire        AS_,
    // Chip side
    input  wire        dreqN_i,
    input  byteT       scsiRdData_i,
    output chipStrobeT chip_o,
    output byteT       scsiWrData_o,
    // CPU side
    input  wire        cpuReq_i,
    input  wire        cpuRw_i,
    input  byteT       cpuWrData_i,
    output logic       cpuAck_o,
    output byteT       cpuRdData_o,
    // Memory side
    input  wire        memPush_i,
    input  longT       memWrData_i,
    input  wire        memPop_i,
    output longT       memRdData_o,
    output logic       fifoFull_o,
    output logic       fifoEmpty_o,
    input  wire        dmaDir_i         // Change only while idle
);

    dmaCtlT dmaCtl;
    logic   boEq3;
    logic   full;
    logic   empty;
    logic   packPush;
    logic   packPop;
    longT   packedLong;
    longT   headLong;
    byteT   laneByte;

    scsiSeqCtrl i_seq (
        .CLK135, .AS_, .dreqN_i, .cpuReq_i, .cpuRw_i, .dmaDir_i,
        .boEq3_i(boEq3), .fifoFull_i(full), .fifoEmpty_i(empty),
        .chip_o, .dmaCtl_o(dmaCtl), .cpuAck_o
    );

    longFifo #(.FifoDepthLog2(FifoDepthLog2)) i_fifo (
        .CLK135, .AS_,
        .packPush_i(packPush), .packedLong_i(packedLong), .packPop_i(packPop),
        .memPush_i, .memWrData_i, .memPop_i,
        .headLong_o(headLong), .full_o(full), .empty_o(empty)
    );

    laneAssembler i_lanes (
        .CLK135, .AS_, .dmaCtl_i(dmaCtl), .scsiRdData_i, .headLong_i(headLong),
        .laneByte_o(laneByte), .boEq3_o(boEq3), .packedLong_o(packedLong),
        .packPush_o(packPush), .packPop_o(packPop)
    );

    chipBusPort i_bus (
        .CLK135, .AS_, .dmaCtl_i(dmaCtl), .cpuWrData_i, .laneByte_i(laneByte),
        .scsiRdData_i, .scsiWrData_o, .cpuRdData_o
    );

    assign memRdData_o = headLong;   // Head is show-ahead
    assign fifoFull_o  = full;
    assign fifoEmpty_o = empty;

endmodule

`default_nettype wire

// File: verilog/scsiSeqCtrl.sv
`default_nettype none

module scsiSeqCtrl
    import scsiDmaPkg::*;
(
    input  wire        CLK135,
    input  wire        AS_,          // Async reset, active high
    input  wire        dreqN_i,      // Chip DMA request, active low
    input  wire        cpuReq_i,     // CPU register access request
    input  wire        cpuRw_i,      // 1 = read
    input  wire        dmaDir_i,     // 0 = SCSI to FIFO, 1 = FIFO to SCSI
    input  wire        boEq3_i,      // Byte pointer on last lane
    input  wire        fifoFull_i,
    input  wire        fifoEmpty_i,
    output chipStrobeT chip_o,
    output dmaCtlT     dmaCtl_o,
    output logic       cpuAck_o
);

    logic     dreqNSync;             // Registered chip request
    logic     cpuReqSync;            // Registered CPU request
    logic     dmaGo;                 // DMA byte may go this cycle
    seqStateT state;
    seqStateT nextState;

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            dreqNSync  <= 1'b1;      // Idle request level
            cpuReqSync <= 1'b0;
        end else begin
            dreqNSync  <= dreqN_i;
            cpuReqSync <= cpuReq_i;
        end
    end

    // Packing direction stalls only when a full longword has nowhere to go
    assign dmaGo = !dreqNSync &&
                   (dmaDir_i ? !fifoEmpty_i : !(boEq3_i && fifoFull_i));

    always_comb begin
        nextState = state;
        case (state)
            Idle, DmaRecover: begin  // Arbitration point, CPU first
                if (cpuReqSync)
                    nextState = CpuAccess;
                else if (dmaGo)
                    nextState = DmaStrobe;
                else
                    nextState = Idle;
            end
            CpuAccess:  nextState = CpuDone;
            CpuDone:    nextState = cpuReqSync ? CpuDone : Idle;  // Wait for req release
            DmaStrobe:  nextState = DmaRecover;
            default:    nextState = Idle;
        endcase
    end

    // Strobes decoded from next state so they line up with the state register
    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            state    <= Idle;
            chip_o   <= '0;
            dmaCtl_o <= '0;
            cpuAck_o <= 1'b0;
        end else begin
            state          <= nextState;
            chip_o.cs      <= (nextState == CpuAccess);
            chip_o.re      <= ((nextState == CpuAccess) && cpuRw_i) ||
                              ((nextState == DmaStrobe) && !dmaDir_i);
            chip_o.we      <= ((nextState == CpuAccess) && !cpuRw_i) ||
                              ((nextState == DmaStrobe) && dmaDir_i);
            chip_o.dack    <= (nextState == DmaStrobe);
            dmaCtl_o.s2f   <= (nextState == DmaStrobe) && !dmaDir_i;
            dmaCtl_o.f2s   <= (nextState == DmaStrobe) && dmaDir_i;
            dmaCtl_o.cpu2s <= (nextState == CpuAccess) && !cpuRw_i;
            dmaCtl_o.s2cpu <= (nextState == CpuAccess) && cpuRw_i;
            cpuAck_o       <= (state == CpuAccess) && (nextState == CpuDone);  // One pulse
        end
    end

    // Chip never sees both directions at once
    assert property (@(posedge CLK135) disable iff (AS_) !(chip_o.re && chip_o.we))
        else $error("scsiSeqCtrl: re and we high together");

    // DMA acknowledge only in strobe state, never during a CPU cycle
    assert property (@(posedge CLK135) disable iff (AS_)
                     chip_o.dack |-> (state == DmaStrobe) && !chip_o.cs)
        else $error("scsiSeqCtrl: dack outside DmaStrobe");

endmodule

`default_nettype wire
